// File: design/store_settings.svh
`ifndef STORE_SETTINGS_SVH
`define STORE_SETTINGS_SVH

// ========================================
// Store buffer geometry
// ========================================

// Number of buffer entries, must be a power of two so the pointers wrap
`define STORE_BUFFER_SIZE 4

// ========================================
// Machine-only memory region
// ========================================

// Inclusive byte address bounds, writes here need machine privilege
`define PRIVATE_REGION_START 32'h0000_1000
`define PRIVATE_REGION_END   32'h0000_1FFF

`endif

// File: design/store_pkg.sv
package store_pkg;

    // ========================================
    // Basic words
    // ========================================

    // One data or address word of the core
    typedef logic [31:0] data_word_t;

    // Byte address without the two offset bits, used by forwarding lookups
    typedef logic [29:0] word_address_t;

    // ========================================
    // Store width and operation
    // ========================================

    // Width of a store as it travels with the buffer entry
    typedef enum logic [1:0] {
        BYTE = 2'b00,
        HALF = 2'b01,
        WORD = 2'b10
    } store_width_t;

    // Store micro-operation coming from issue
    // Same encoding as store_width_t so a plain cast converts one to the other
    typedef enum logic [1:0] {
        STB = 2'b00,
        STH = 2'b01,
        STW = 2'b10
    } stu_uop_t;

    // ========================================
    // Buffer entry
    // ========================================

    // A store as held by the buffer and presented to memory, 66 bits
    typedef struct packed {
        data_word_t   data;
        data_word_t   address;
        store_width_t width;
    } store_entry_t;

endpackage : store_pkg

// File: design/store_buffer.sv
`include "store_settings.svh"

module store_buffer (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   flush_i,

    // Push side from the store unit
    input  logic                   push_i,
    input  store_pkg::store_entry_t push_entry_i,
    output logic                   full_o,
    output logic                   empty_o,

    // Commit stage marks the oldest uncommitted entry
    input  logic                   validate_i,

    // Memory controller port
    output logic                   store_request_o,
    output store_pkg::store_entry_t store_entry_o,
    input  logic                   store_done_i,

    // Load forwarding lookup
    input  store_pkg::word_address_t forward_address_i,
    output store_pkg::data_word_t    forward_data_o,
    output logic                     forward_match_o
);

    import store_pkg::*;

    // ========================================
    // Storage and pointers
    // ========================================

    localparam int DEPTH = `STORE_BUFFER_SIZE;
    localparam int PTR_W = $clog2(DEPTH);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [PTR_W:0]   count_t;

    // Entry array, payload only
    store_entry_t entry_q [DEPTH];

    // Head is the oldest entry, commit points past the last validated one,
    // tail is where the next push lands
    ptr_t head_q, head_d;
    ptr_t commit_q, commit_d;
    ptr_t tail_q, tail_d;

    // Total occupancy and number of entries that are validated but not drained
    count_t count_q, count_d;
    count_t committed_q, committed_d;

    logic push_fire;
    logic pop_fire;
    logic validate_fire;
    logic uncommitted;

    // ========================================
    // Status and handshakes
    // ========================================

    assign full_o  = (count_q == count_t'(DEPTH));
    assign empty_o = (count_q == '0);

    // A push is dropped silently when full, the store unit retries it
    assign push_fire = push_i & ~full_o;

    // Memory sees a request as long as at least one entry is committed
    // This level only falls through a pop since flush keeps committed entries
    assign store_request_o = (committed_q != '0);
    assign store_entry_o   = entry_q[head_q];
    assign pop_fire        = store_request_o & store_done_i;

    // Something is waiting for validation, possibly the entry pushed right now
    // A push under flush is discarded, so it cannot be validated either
    assign uncommitted   = (count_q != committed_q) | (push_fire & ~flush_i);
    assign validate_fire = validate_i & uncommitted;

    // ========================================
    // Pointer update
    // ========================================

    always_comb begin : pointer_update
        head_d      = head_q + ptr_t'(pop_fire);
        commit_d    = commit_q + ptr_t'(validate_fire);
        committed_d = committed_q + count_t'(validate_fire) - count_t'(pop_fire);

        if (flush_i) begin
            // Drop everything younger than the commit pointer
            tail_d  = commit_d;
            count_d = committed_d;
        end else begin
            tail_d  = tail_q + ptr_t'(push_fire);
            count_d = count_q + count_t'(push_fire) - count_t'(pop_fire);
        end
    end : pointer_update

    always_ff @(posedge clk_i) begin : pointer_regs
        if (!rst_n_i) begin
            head_q      <= '0;
            commit_q    <= '0;
            tail_q      <= '0;
            count_q     <= '0;
            committed_q <= '0;
        end else begin
            head_q      <= head_d;
            commit_q    <= commit_d;
            tail_q      <= tail_d;
            count_q     <= count_d;
            committed_q <= committed_d;
        end
    end : pointer_regs

    // New entries are written at the tail
    always_ff @(posedge clk_i) begin : entry_write
        if (push_fire) begin
            entry_q[tail_q] <= push_entry_i;
        end
    end : entry_write

    // ========================================
    // Forwarding search
    // ========================================

    // Walk from the youngest entry towards the head and stop at the first
    // occupied entry whose word address matches
    always_comb begin : forward_search
        ptr_t       idx;
        logic       hit;
        data_word_t hit_data;

        hit      = 1'b0;
        hit_data = '0;
        idx      = '0;

        for (int k = 0; k < DEPTH; k++) begin
            // Offset k counts back from the tail, so k equal to 0 is the youngest
            idx = tail_q - ptr_t'(k + 1);

            if (!hit && (count_t'(k) < count_q)) begin
                if (entry_q[idx].address[31:2] == forward_address_i) begin
                    hit      = 1'b1;
                    hit_data = entry_q[idx].data;
                end
            end
        end

        forward_match_o = hit;
        forward_data_o  = hit_data;
    end : forward_search

endmodule : store_buffer

// File: design/store_unit.sv
`include "store_settings.svh"

module store_unit (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     stall_i,
    input  logic                     flush_i,

    // Issue side
    input  logic                     privilege_i,
    input  logic                     valid_operation_i,
    input  store_pkg::data_word_t    store_data_i,
    input  store_pkg::data_word_t    store_address_i,
    input  store_pkg::stu_uop_t      operation_i,

    // Writeback holds the result while not ready
    input  logic                     wait_i,

    // Commit stage validation pulse
    input  logic                     validate_i,

    // Load forwarding
    input  store_pkg::word_address_t forward_address_i,
    output store_pkg::data_word_t    forward_data_o,
    output logic                     forward_match_o,

    // Status and result
    output logic                     buffer_empty_o,
    output logic                     idle_o,
    output logic                     illegal_access_o,
    output logic                     misaligned_o,
    output logic                     data_valid_o,

    // Memory controller port
    output logic                     store_request_o,
    output store_pkg::store_entry_t  store_entry_o,
    input  logic                     store_done_i
);

    import store_pkg::*;

    // ========================================
    // Address checks
    // ========================================

    logic misaligned;
    logic private_region;
    logic illegal;

    // Half words sit on even addresses, words on multiples of four
    always_comb begin : alignment_check
        case (operation_i)
            STB:     misaligned = 1'b0;
            STH:     misaligned = store_address_i[0];
            STW:     misaligned = (store_address_i[1:0] != 2'b00);
            default: misaligned = 1'b0;
        endcase
    end : alignment_check

    assign private_region = (store_address_i >= `PRIVATE_REGION_START) &&
                            (store_address_i <= `PRIVATE_REGION_END);

    // Only machine privilege may write inside the private region
    assign illegal = private_region & ~privilege_i;

    // ========================================
    // Held store and saved flags
    // ========================================

    typedef enum logic [1:0] {
        IDLE,
        WAIT_BUFFER,
        WAIT_ACCEPT
    } state_t;

    state_t state_q, state_d;

    store_entry_t issue_entry;
    store_entry_t held_q;
    logic         misaligned_q;
    logic         illegal_q;

    assign issue_entry = '{
        data:    store_data_i,
        address: store_address_i,
        width:   store_width_t'(operation_i)
    };

    // Captured on the issue strobe, used for the push retry and the flag replay
    always_ff @(posedge clk_i) begin : held_regs
        if ((state_q == IDLE) && valid_operation_i) begin
            held_q       <= issue_entry;
            misaligned_q <= misaligned;
            illegal_q    <= illegal;
        end
    end : held_regs

    // ========================================
    // Acceptance FSM
    // ========================================

    logic         push;
    store_entry_t push_entry;
    logic         buffer_full;
    logic         held_match;

    always_ff @(posedge clk_i) begin : state_reg
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else if (flush_i) begin
            state_q <= IDLE;
        end else if (!stall_i) begin
            state_q <= state_d;
        end
    end : state_reg

    always_comb begin : fsm_next
        state_d          = state_q;
        idle_o           = 1'b0;
        data_valid_o     = 1'b0;
        misaligned_o     = 1'b0;
        illegal_access_o = 1'b0;
        push             = 1'b0;
        push_entry       = issue_entry;
        held_match       = 1'b0;

        case (state_q)
            IDLE: begin
                idle_o = 1'b1;

                if (valid_operation_i) begin
                    if (misaligned | illegal) begin
                        // Rejected stores answer at once and never touch the buffer
                        data_valid_o     = 1'b1;
                        misaligned_o     = misaligned;
                        illegal_access_o = illegal;

                        if (wait_i) begin
                            state_d = WAIT_ACCEPT;
                            idle_o  = 1'b0;
                        end
                    end else begin
                        push = 1'b1;

                        if (!buffer_full) begin
                            data_valid_o = 1'b1;

                            if (wait_i) begin
                                state_d = WAIT_ACCEPT;
                                idle_o  = 1'b0;
                            end
                        end else begin
                            // Keep the store in held_q and retry next cycle
                            state_d = WAIT_BUFFER;
                            idle_o  = 1'b0;
                        end
                    end
                end
            end

            WAIT_BUFFER: begin
                push       = 1'b1;
                push_entry = held_q;

                // The held store is younger than anything already buffered
                held_match = (forward_address_i == held_q.address[31:2]);

                if (!buffer_full) begin
                    data_valid_o = 1'b1;

                    if (wait_i) begin
                        state_d = WAIT_ACCEPT;
                    end else begin
                        state_d = IDLE;
                    end
                end
            end

            WAIT_ACCEPT: begin
                // Replay the flags of the store that is still awaiting writeback
                data_valid_o     = 1'b1;
                misaligned_o     = misaligned_q;
                illegal_access_o = illegal_q;

                // Back to IDLE on the next edge, issue waits one more cycle
                if (!wait_i) begin
                    state_d = IDLE;
                end
            end

            default: begin
                state_d = IDLE;
            end
        endcase
    end : fsm_next

    // ========================================
    // Store buffer and forwarding
    // ========================================

    data_word_t buffer_forward_data;
    logic       buffer_match;

    store_buffer u_store_buffer (
        .clk_i             ( clk_i               ),
        .rst_n_i           ( rst_n_i             ),
        .flush_i           ( flush_i             ),
        .push_i            ( push                ),
        .push_entry_i      ( push_entry          ),
        .full_o            ( buffer_full         ),
        .empty_o           ( buffer_empty_o      ),
        .validate_i        ( validate_i          ),
        .store_request_o   ( store_request_o     ),
        .store_entry_o     ( store_entry_o       ),
        .store_done_i      ( store_done_i        ),
        .forward_address_i ( forward_address_i   ),
        .forward_data_o    ( buffer_forward_data ),
        .forward_match_o   ( buffer_match        )
    );

    // Held store wins over the buffer when both match
    assign forward_data_o  = held_match ? held_q.data : buffer_forward_data;
    assign forward_match_o = held_match | buffer_match;

endmodule : store_unit

// File: dv/store_unit_checker.sv
module store_unit_checker (
    input logic                    clk_i,
    input logic                    rst_n_i,
    input logic                    data_valid_i,
    input logic                    misaligned_i,
    input logic                    illegal_access_i,
    input logic                    idle_i,
    input logic                    buffer_empty_i,
    input logic                    store_request_i,
    input logic                    store_done_i,
    input store_pkg::store_entry_t store_entry_i,
    input logic                    forward_match_i,
    input store_pkg::data_word_t   forward_data_i
);
    timeunit 1ns;
    timeprecision 100ps;

    import store_pkg::*;

    int           value_errors = 0;
    int           other_errors = 0;
    int           stall_cycles = 0;
    string        flag_name;
    logic         flags_armed = 1'b0;
    logic         exp_misaligned;
    logic         exp_illegal;
    logic         request_seen = 1'b0;
    logic         done_seen = 1'b0;
    store_entry_t exp_writes[$];
    string        write_names[$];

    // ========================================
    // Expectations from the testbench
    // ========================================

    task automatic expect_flags(input string name, input logic mis, input logic ill);
        flag_name      = name;
        exp_misaligned = mis;
        exp_illegal    = ill;
        flags_armed    = 1'b1;
    endtask

    task automatic expect_write(input string name, input store_entry_t entry);
        write_names.push_back(name);
        exp_writes.push_back(entry);
    endtask

    task automatic check_forward(input string name, input logic match, input data_word_t data);
        @(posedge clk_i);
        if (forward_match_i !== match) begin
            value_errors++;
            $display("FAILED %s forward match: expected %0b, actual %0b", name, match,
                     forward_match_i);
        end else if (match && (forward_data_i !== data)) begin
            value_errors++;
            $display("FAILED %s forward data: expected %h, actual %h", name, data,
                     forward_data_i);
        end
    endtask

    task automatic clear_stall();
        stall_cycles = 0;
    endtask

    task automatic check_stall(input string name, input logic stalled);
        if ((stall_cycles != 0) !== stalled) begin
            value_errors++;
            $display("FAILED %s buffer stall: expected %0b, actual %0b", name, stalled,
                     stall_cycles != 0);
        end
    endtask

    task automatic report_fault(input string msg);
        other_errors++;
        $display("%s", msg);
    endtask

    function automatic int pending_writes();
        return exp_writes.size();
    endfunction

    function automatic int error_total();
        return value_errors + other_errors;
    endfunction

    // Writes still queued here were validated but never reached memory
    task automatic finish_checks();
        if (exp_writes.size() != 0) begin
            other_errors++;
            $display("%0d validated stores never reached memory", exp_writes.size());
        end
        $display("errors: %0d value mismatches, %0d other faults", value_errors, other_errors);
    endtask

    // ========================================
    // Port monitor
    // ========================================

    always @(posedge clk_i) begin : port_watch
        if (rst_n_i) begin
            // Flags hold steady through every cycle of a result and through its replays
            if (data_valid_i && flags_armed) begin
                if (misaligned_i !== exp_misaligned) begin
                    value_errors++;
                    $display("FAILED %s misaligned: expected %0b, actual %0b", flag_name,
                             exp_misaligned, misaligned_i);
                end
                if (illegal_access_i !== exp_illegal) begin
                    value_errors++;
                    $display("FAILED %s illegal access: expected %0b, actual %0b", flag_name,
                             exp_illegal, illegal_access_i);
                end
            end

            // Not idle and no result means a store is stuck waiting for buffer space
            if (!idle_i && !data_valid_i) begin
                stall_cycles++;
            end

            // Every validated store that memory has not taken yet still sits in the buffer
            if (buffer_empty_i && (exp_writes.size() != 0)) begin
                report_fault("buffer reported empty while validated stores were still waiting");
            end

            if (store_request_i && store_done_i) begin
                if (exp_writes.size() == 0) begin
                    report_fault("memory write arrived with no pending store");
                end else begin
                    if (store_entry_i !== exp_writes[0]) begin
                        value_errors++;
                        $display("FAILED %s memory write: expected %h, actual %h",
                                 write_names[0], exp_writes[0], store_entry_i);
                    end
                    void'(exp_writes.pop_front());
                    void'(write_names.pop_front());
                end
            end

            if (request_seen && !done_seen && !store_request_i) begin
                report_fault("memory request dropped before the memory accepted it");
            end
            request_seen <= store_request_i;
            done_seen    <= store_done_i;
        end
    end : port_watch

endmodule : store_unit_checker

// File: dv/store_unit_tb.sv
`include "store_settings.svh"

module store_unit_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import store_pkg::*;

    // One line of the tests file without the name and kind
    typedef struct packed {
        logic       privilege;
        logic [1:0] operation;
        data_word_t address;
        data_word_t data;
        logic [7:0] wait_cycles;
        logic [7:0] mem_delay;
        logic       exp_misaligned;
        logic       exp_illegal;
        logic       exp_match;
        data_word_t exp_data;
    } test_vec_t;

    logic          clk_i, rst_n_i, stall_i, flush_i, privilege_i, valid_operation_i;
    data_word_t    store_data_i, store_address_i, forward_data_o;
    stu_uop_t      operation_i;
    logic          wait_i, validate_i, forward_match_o, buffer_empty_o, idle_o;
    word_address_t forward_address_i;
    logic          illegal_access_o, misaligned_o, data_valid_o, store_request_o;
    store_entry_t  store_entry_o;
    logic          store_done_i;

    string         test_names[$];
    string         test_kinds[$];
    test_vec_t     test_vecs[$];
    string         pending_names[$];
    store_entry_t  pending_entries[$];
    logic [31:0]   lfsr_state = 32'd91081;
    int            mem_extra = 0;
    int            cycle_limit = 0;
    int            cycle_count = 0;

    store_unit u_store_unit (.*);

    store_unit_checker u_checker (
        .clk_i            ( clk_i            ),
        .rst_n_i          ( rst_n_i          ),
        .data_valid_i     ( data_valid_o     ),
        .misaligned_i     ( misaligned_o     ),
        .illegal_access_i ( illegal_access_o ),
        .idle_i           ( idle_o           ),
        .buffer_empty_i   ( buffer_empty_o   ),
        .store_request_i  ( store_request_o  ),
        .store_done_i     ( store_done_i     ),
        .store_entry_i    ( store_entry_o    ),
        .forward_match_i  ( forward_match_o  ),
        .forward_data_i   ( forward_data_o   )
    );

    initial begin : clock_gen
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end : clock_gen

    // ========================================
    // Memory responder
    // ========================================

    // Galois LFSR with the feedback x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    function automatic int take_random_bits(input int count);
        int value;
        value = 0;
        for (int b = 0; b < count; b++) begin
            value      = (value << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_step(lfsr_state);
        end
        return value;
    endfunction

    // Each request waits a random 0 to 7 cycles plus the delay of the current test
    initial begin : memory_responder
        int   delay_left;
        logic counting;
        delay_left   = 0;
        counting     = 1'b0;
        store_done_i = 1'b0;
        forever begin
            @(negedge clk_i);
            store_done_i = 1'b0;
            if (rst_n_i && store_request_o) begin
                if (!counting) begin
                    delay_left = take_random_bits(3) + mem_extra;
                    counting   = 1'b1;
                end
                if (delay_left == 0) begin
                    store_done_i = 1'b1;
                    counting     = 1'b0;
                end else begin
                    delay_left--;
                end
            end
        end
    end : memory_responder

    // ========================================
    // Stimulus tasks
    // ========================================

    task automatic wait_idle();
        do @(posedge clk_i); while (!idle_o);
    endtask

    task automatic wait_empty();
        do @(posedge clk_i); while (!buffer_empty_o);
    endtask

    // Commit the oldest store that is still waiting for validation
    task automatic validate_oldest();
        if (pending_entries.size() != 0) begin
            @(negedge clk_i);
            u_checker.expect_write(pending_names.pop_front(), pending_entries.pop_front());
            validate_i = 1'b1;
            @(negedge clk_i);
            validate_i = 1'b0;
        end
    endtask

    task automatic issue_store(input string name, input test_vec_t vec, input data_word_t address,
                               input data_word_t data, input logic validate);
        store_entry_t entry;
        logic         accepted;
        entry.data    = data;
        entry.address = address;
        entry.width   = store_width_t'(vec.operation);
        u_checker.expect_flags(name, vec.exp_misaligned, vec.exp_illegal);
        @(negedge clk_i);
        privilege_i       = vec.privilege;
        store_data_i      = data;
        store_address_i   = address;
        operation_i       = stu_uop_t'(vec.operation);
        wait_i            = (vec.wait_cycles != 0);
        valid_operation_i = 1'b1;
        // A full buffer delays the result until space frees up
        do begin
            @(posedge clk_i);
            accepted = data_valid_o;
            @(negedge clk_i);
            valid_operation_i = 1'b0;
        end while (!accepted);
        if (vec.wait_cycles > 1) begin
            repeat (vec.wait_cycles - 1) @(negedge clk_i);
        end
        wait_i = 1'b0;
        wait_idle();
        // Only a legal store lands in the buffer
        if (!vec.exp_misaligned && !vec.exp_illegal) begin
            pending_names.push_back(name);
            pending_entries.push_back(entry);
        end
        if (validate) begin
            validate_oldest();
        end
    endtask

    task automatic run_test(input string name, input string kind, input test_vec_t vec);
        // The fill test starts from an empty buffer so the stall is certain
        if (kind == "fill") begin
            wait_empty();
            u_checker.clear_stall();
        end
        mem_extra = vec.mem_delay;
        if (kind == "store" || kind == "validate") begin
            issue_store(name, vec, vec.address, vec.data, kind == "validate");
        end else if (kind == "fill") begin
            for (int k = 0; k <= `STORE_BUFFER_SIZE; k++) begin
                issue_store(name, vec, vec.address + 4 * k, vec.data + k, 1'b1);
            end
            u_checker.check_stall(name, vec.exp_match);
        end else if (kind == "forward") begin
            @(negedge clk_i);
            forward_address_i = vec.address[31:2];
            u_checker.check_forward(name, vec.exp_match, vec.exp_data);
        end else if (kind == "flush") begin
            @(negedge clk_i);
            flush_i = 1'b1;
            @(negedge clk_i);
            flush_i = 1'b0;
            pending_names.delete();
            pending_entries.delete();
        end else begin
            u_checker.report_fault({"unknown test kind in the tests file: ", kind});
        end
    endtask

    // ========================================
    // Main sequence
    // ========================================

    initial begin : main_sequence
        int          fd;
        int          fields;
        string       line, name, kind;
        logic [31:0] f_priv, f_op, f_mis, f_ill, f_match;
        data_word_t  f_addr, f_data, f_fwd;
        int          f_wait, f_mem;
        test_vec_t   vec;
        rst_n_i           = 1'b0;
        stall_i           = 1'b0;
        flush_i           = 1'b0;
        privilege_i       = 1'b0;
        valid_operation_i = 1'b0;
        store_data_i      = '0;
        store_address_i   = '0;
        operation_i       = STB;
        wait_i            = 1'b0;
        validate_i        = 1'b0;
        forward_address_i = '0;

        fd = $fopen("dv/store_unit_tests.txt", "r");
        if (fd == 0) begin
            u_checker.report_fault("could not open the tests file");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line.getc(0) != "#") begin
                    fields = $sscanf(line, "%s %s %h %h %h %h %d %d %h %h %h %h", name, kind,
                                     f_priv, f_op, f_addr, f_data, f_wait, f_mem, f_mis, f_ill,
                                     f_match, f_fwd);
                    if (fields == 12) begin
                        vec.privilege      = f_priv[0];
                        vec.operation      = f_op[1:0];
                        vec.address        = f_addr;
                        vec.data           = f_data;
                        vec.wait_cycles    = f_wait[7:0];
                        vec.mem_delay      = f_mem[7:0];
                        vec.exp_misaligned = f_mis[0];
                        vec.exp_illegal    = f_ill[0];
                        vec.exp_match      = f_match[0];
                        vec.exp_data       = f_fwd;
                        test_names.push_back(name);
                        test_kinds.push_back(kind);
                        test_vecs.push_back(vec);
                    end else begin
                        u_checker.report_fault("a line of the tests file could not be parsed");
                    end
                end
            end
            $fclose(fd);
        end
        cycle_limit = 40 * test_vecs.size() + 200;

        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;

        foreach (test_vecs[i]) begin
            run_test(test_names[i], test_kinds[i], test_vecs[i]);
        end

        // Everything validated must drain before the run can end
        do @(posedge clk_i); while (!buffer_empty_o || u_checker.pending_writes() != 0);
        u_checker.finish_checks();
        if (u_checker.error_total() == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end : main_sequence

    initial begin : cycle_guard
        wait (cycle_limit != 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk_i);
            cycle_count++;
        end
        u_checker.report_fault("timeout, the run reached its cycle limit");
        u_checker.finish_checks();
        $display("test failed");
        $finish;
    end : cycle_guard

endmodule : store_unit_tb

// File: dv/store_unit_tests.txt
# name kind priv op addr data wait_cycles mem_delay exp_misaligned exp_illegal exp_match exp_data
# op 0 byte, 1 half, 2 word, fill uses exp_match as the expected buffer stall
byte_odd       validate 0 0 00000203 000000a1 0 0  0 0 0 00000000
half_even      validate 0 1 00000206 0000b2b2 0 0  0 0 0 00000000
half_odd       store    0 1 00000207 0000dead 0 0  1 0 0 00000000
word_aligned   validate 0 2 00000208 c3c3c3c3 0 0  0 0 0 00000000
word_off1      store    0 2 00000209 12345678 1 0  1 0 0 00000000
word_off2      store    0 2 0000020a 12345678 0 0  1 0 0 00000000
word_off3      store    1 2 0000120b 12345678 2 0  1 0 0 00000000
priv_user      store    0 2 00001000 aaaa0001 0 0  0 1 0 00000000
priv_machine   validate 1 2 00001000 bbbb0002 0 0  0 0 0 00000000
priv_end_user  store    0 0 00001fff 000000cc 0 0  0 1 0 00000000
priv_end_mach  validate 1 0 00001fff 000000cd 0 0  0 0 0 00000000
priv_above     validate 0 2 00002000 dddd0004 0 0  0 0 0 00000000
priv_below     validate 0 1 00000ffe 0000eeee 0 0  0 0 0 00000000
both_bad       store    0 1 00001001 0000f00d 0 0  1 1 0 00000000
wait_legal     validate 0 2 00000300 0f0f0f0f 4 0  0 0 0 00000000
wait_reject    store    0 2 00001004 99990000 3 0  0 1 0 00000000
fill_buffer    fill     0 2 00000400 40000000 0 40 0 0 1 00000000
order_a        validate 0 2 00000500 50000001 0 0  0 0 0 00000000
order_b        validate 0 0 00000504 000000b2 0 0  0 0 0 00000000
fwd_commit     validate 0 2 00000600 60000001 0 0  0 0 0 00000000
fwd_older      store    0 2 00000700 70000001 0 0  0 0 0 00000000
fwd_younger    store    0 1 00000702 0000ffff 0 0  0 0 0 00000000
fwd_hit        forward  0 0 00000701 00000000 0 0  0 0 1 0000ffff
fwd_miss       forward  0 0 00000800 00000000 0 0  0 0 0 00000000
flush_drop     flush    0 0 00000000 00000000 0 0  0 0 0 00000000
post_flush     validate 0 2 00000704 77770001 2 0  0 0 0 00000000
fwd_gone       forward  0 0 00000700 00000000 0 0  0 0 0 00000000

// File: compile.f
+incdir+design
design/store_pkg.sv
design/store_buffer.sv
design/store_unit.sv
dv/store_unit_checker.sv
dv/store_unit_tb.sv
